/* rtl/rv_decode_pkg.sv */
package rv_decode_pkg;

    // Base opcodes
    localparam logic [6:0] op_r     = 7'b0110011;
    localparam logic [6:0] op_i     = 7'b0010011;
    localparam logic [6:0] op_s     = 7'b0100011;
    localparam logic [6:0] op_l     = 7'b0000011;
    localparam logic [6:0] op_b     = 7'b1100011;
    localparam logic [6:0] op_lui   = 7'b0110111;
    localparam logic [6:0] op_auipc = 7'b0010111;
    localparam logic [6:0] op_jal   = 7'b1101111;
    localparam logic [6:0] op_jalr  = 7'b1100111;

    // Matrix accelerator, custom-0 opcode space
    localparam logic [6:0] op_acc   = 7'b0001011;

    // Accelerator funct3, 3'b101 and up are unused
    localparam logic [2:0] acc_load   = 3'b000;
    localparam logic [2:0] acc_save   = 3'b001;
    localparam logic [2:0] acc_matmul = 3'b010;
    localparam logic [2:0] acc_reset  = 3'b011;
    localparam logic [2:0] acc_move   = 3'b100;

    // Write-back source
    localparam logic [1:0] src_alu = 2'b00;
    localparam logic [1:0] src_mem = 2'b01;
    localparam logic [1:0] src_pc  = 2'b10;

    // Operation code handed to the accelerator
    localparam logic [2:0] acc_none      = 3'd0;
    localparam logic [2:0] acc_op_load   = 3'd1;
    localparam logic [2:0] acc_op_save   = 3'd2;
    localparam logic [2:0] acc_op_matmul = 3'd3;
    localparam logic [2:0] acc_op_reset  = 3'd4;
    localparam logic [2:0] acc_op_move   = 3'd5;

    // Fetched instruction word, R layout and S layout
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r;
        struct packed {
            logic [6:0] imm_hi;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] imm_lo;
            logic [6:0] opcode;
        } s;
    } instr_u;

endpackage

/* rtl/ctrl_if.sv */
interface ctrl_if;

    logic [4:0] rs1_addr;
    logic [4:0] rs2_addr;
    logic [4:0] rd_addr;
    logic [2:0] funct3;
    logic [1:0] reg_src;
    logic       branch;
    logic       jal;
    logic       jalr;
    logic       mem_read;
    logic       mem_write;
    logic       reg_write;
    logic [2:0] acc_op;
    logic       illegal;

    modport dec (
        output rs1_addr, rs2_addr, rd_addr, funct3, reg_src,
        output branch, jal, jalr, mem_read, mem_write, reg_write,
        output acc_op, illegal
    );

    modport merge (
        input rs1_addr, rs2_addr, rd_addr, funct3, reg_src,
        input branch, jal, jalr, mem_read, mem_write, reg_write,
        input acc_op, illegal
    );

endinterface

/* rtl/control_decoder.sv */
module control_decoder import rv_decode_pkg::*; (
    input  instr_u instr,
    ctrl_if.dec    ctl
);

    logic [6:0] opcode;
    logic [2:0] funct3;

    assign opcode = instr.r.opcode;
    assign funct3 = instr.r.funct3;

    // Register fields pass straight through
    assign ctl.rs1_addr = instr.r.rs1;
    assign ctl.rs2_addr = instr.r.rs2;
    assign ctl.rd_addr  = instr.r.rd;
    assign ctl.funct3   = funct3;

    always_comb begin
        ctl.branch    = 1'b0;
        ctl.jal       = 1'b0;
        ctl.jalr      = 1'b0;
        ctl.mem_read  = 1'b0;
        ctl.mem_write = 1'b0;
        ctl.reg_write = 1'b0;
        ctl.reg_src   = src_alu;
        ctl.acc_op    = acc_none;
        ctl.illegal   = 1'b0;

        case (opcode)
            op_r: begin
                ctl.reg_write = 1'b1;       // ADD SUB SLL ... AND
            end
            op_i: begin
                ctl.reg_write = 1'b1;       // ADDI ... ANDI
            end
            op_lui, op_auipc: begin
                ctl.reg_write = 1'b1;
            end
            op_l: begin
                ctl.mem_read  = 1'b1;
                ctl.reg_write = 1'b1;
                ctl.reg_src   = src_mem;
            end
            op_s: begin
                ctl.mem_write = 1'b1;
                ctl.reg_src   = src_mem;    // Don't care, kept as memory
            end
            op_b: begin
                ctl.branch = 1'b1;
            end
            op_jal: begin
                ctl.jal       = 1'b1;
                ctl.reg_write = 1'b1;
                ctl.reg_src   = src_pc;     // Link address
            end
            op_jalr: begin
                ctl.jalr      = 1'b1;
                ctl.reg_write = 1'b1;
                ctl.reg_src   = src_pc;
            end
            op_acc: begin
                // Extension functions select on funct3 alone
                case (funct3)
                    acc_load: begin
                        ctl.mem_read  = 1'b1;
                        ctl.reg_write = 1'b1;
                        ctl.reg_src   = src_mem;
                        ctl.acc_op    = acc_op_load;
                    end
                    acc_save: begin
                        ctl.mem_write = 1'b1;
                        ctl.reg_src   = src_mem;
                        ctl.acc_op    = acc_op_save;
                    end
                    acc_matmul: begin
                        ctl.acc_op = acc_op_matmul;
                    end
                    acc_reset: begin
                        ctl.acc_op = acc_op_reset;
                    end
                    acc_move: begin
                        ctl.acc_op = acc_op_move;
                    end
                    default: begin
                        ctl.reg_src = src_pc;
                        ctl.illegal = 1'b1;  // Unused funct3
                    end
                endcase
            end
            default: begin
                ctl.reg_src = src_pc;
                ctl.illegal = 1'b1;         // Unknown opcode
            end
        endcase
    end

endmodule

/* rtl/imm_gen.sv */
module imm_gen import rv_decode_pkg::*; (
    input  instr_u      instr,
    output logic [31:0] imm
);

    logic        sign;
    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] imm_b;
    logic [31:0] imm_u;
    logic [31:0] imm_j;

    assign sign = instr[31];

    // I format sits where funct7 and rs2 are in the R layout
    assign imm_i = {{20{sign}}, instr.r.funct7, instr.r.rs2};

    assign imm_s = {{20{sign}}, instr.s.imm_hi, instr.s.imm_lo};

    // B and J come from the raw bits
    assign imm_b = {{19{sign}}, sign, instr[7], instr[30:25], instr[11:8], 1'b0};

    assign imm_u = {instr[31:12], 12'b0};

    assign imm_j = {{11{sign}}, sign, instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb begin
        case (instr.r.opcode)
            op_i, op_l, op_jalr, op_acc: begin
                imm = imm_i;
            end
            op_s: begin
                imm = imm_s;
            end
            op_b: begin
                imm = imm_b;
            end
            op_lui, op_auipc: begin
                imm = imm_u;
            end
            op_jal: begin
                imm = imm_j;
            end
            default: begin
                imm = 32'd0;                // R type and unknown
            end
        endcase
    end

endmodule

/* rtl/decode_merge.sv */
module decode_merge import rv_decode_pkg::*; (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        in_valid,
    ctrl_if.merge       ctl,
    input  logic [31:0] imm,
    output logic        out_valid,
    output logic [4:0]  rs1_addr,
    output logic [4:0]  rs2_addr,
    output logic [4:0]  rd_addr,
    output logic [2:0]  funct3,
    output logic [1:0]  reg_src,
    output logic        branch,
    output logic        jal,
    output logic        jalr,
    output logic        mem_read,
    output logic        mem_write,
    output logic        reg_write,
    output logic [2:0]  acc_op,
    output logic        illegal,
    output logic [31:0] imm_q
);

    logic rd_zero;

    assign rd_zero = (ctl.rd_addr == 5'd0);

    // One pulse per accepted word
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rs1_addr  <= 5'd0;
            rs2_addr  <= 5'd0;
            rd_addr   <= 5'd0;
            funct3    <= 3'd0;
            reg_src   <= src_alu;
            branch    <= 1'b0;
            jal       <= 1'b0;
            jalr      <= 1'b0;
            mem_read  <= 1'b0;
            mem_write <= 1'b0;
            reg_write <= 1'b0;
            acc_op    <= acc_none;
            illegal   <= 1'b0;
            imm_q     <= 32'd0;
        end else if (in_valid) begin
            rs1_addr  <= ctl.rs1_addr;
            rs2_addr  <= ctl.rs2_addr;
            rd_addr   <= ctl.rd_addr;
            funct3    <= ctl.funct3;
            reg_src   <= ctl.reg_src;
            branch    <= ctl.branch;
            jal       <= ctl.jal;
            jalr      <= ctl.jalr;
            mem_read  <= ctl.mem_read;
            mem_write <= ctl.mem_write;
            reg_write <= ctl.reg_write && !rd_zero;  // x0 is never written
            acc_op    <= ctl.acc_op;
            illegal   <= ctl.illegal;
            imm_q     <= imm;
        end
    end

endmodule

/* rtl/rv_decode.sv */
module rv_decode (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        in_valid,
    input  logic [31:0] instr,
    output logic        out_valid,
    output logic [4:0]  rs1_addr,
    output logic [4:0]  rs2_addr,
    output logic [4:0]  rd_addr,
    output logic [2:0]  funct3,
    output logic [1:0]  reg_src,
    output logic        branch,
    output logic        jal,
    output logic        jalr,
    output logic        mem_read,
    output logic        mem_write,
    output logic        reg_write,
    output logic [2:0]  acc_op,
    output logic        illegal,
    output logic [31:0] imm
);

    logic [31:0] imm_comb;

    ctrl_if ctl_bus ();

    control_decoder u_control_decoder (
        .instr (instr),
        .ctl   (ctl_bus.dec)
    );

    imm_gen u_imm_gen (
        .instr (instr),
        .imm   (imm_comb)
    );

    decode_merge u_decode_merge (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (in_valid),
        .ctl       (ctl_bus.merge),
        .imm       (imm_comb),
        .out_valid (out_valid),
        .rs1_addr  (rs1_addr),
        .rs2_addr  (rs2_addr),
        .rd_addr   (rd_addr),
        .funct3    (funct3),
        .reg_src   (reg_src),
        .branch    (branch),
        .jal       (jal),
        .jalr      (jalr),
        .mem_read  (mem_read),
        .mem_write (mem_write),
        .reg_write (reg_write),
        .acc_op    (acc_op),
        .illegal   (illegal),
        .imm_q     (imm)
    );

endmodule

/* bench/rv_decode_chk.sv */
module rv_decode_chk (
    input logic       clk,
    input logic       arst_n,
    input logic       in_valid,
    input logic       out_valid,
    input logic [4:0] rd_addr,
    input logic       reg_write,
    input logic       mem_read,
    input logic       mem_write,
    input logic       branch,
    input logic       jal,
    input logic       jalr
);

    x0_write: assert property (@(posedge clk) disable iff (!arst_n)
        !(reg_write && rd_addr == 5'd0))
        else $error("reg_write high with rd_addr zero");

    mem_excl: assert property (@(posedge clk) disable iff (!arst_n)
        !(mem_read && mem_write))
        else $error("mem_read and mem_write both high");

    flow_onehot: assert property (@(posedge clk) disable iff (!arst_n)
        $onehot0({branch, jal, jalr}))
        else $error("more than one of branch, jal, jalr high");

    valid_rise: assert property (@(posedge clk) disable iff (!arst_n)
        in_valid |=> out_valid)
        else $error("out_valid missing one cycle after in_valid");

    valid_fall: assert property (@(posedge clk) disable iff (!arst_n)
        !in_valid |=> !out_valid)
        else $error("out_valid high without in_valid");

endmodule

bind rv_decode rv_decode_chk u_rv_decode_chk (.*);

/* bench/rv_decode_tb.sv */
module rv_decode_tb import rv_decode_pkg::*; ();

    logic        clk;
    logic        arst_n;
    logic        in_valid;
    logic [31:0] instr;
    logic        out_valid;
    logic [4:0]  rs1_addr;
    logic [4:0]  rs2_addr;
    logic [4:0]  rd_addr;
    logic [2:0]  funct3;
    logic [1:0]  reg_src;
    logic        branch;
    logic        jal;
    logic        jalr;
    logic        mem_read;
    logic        mem_write;
    logic        reg_write;
    logic [2:0]  acc_op;
    logic        illegal;
    logic [31:0] imm;

    logic [31:0] pat [0:383];       // Three words per test
    int          n_tests;
    int          tests_run;
    int          tests_failed;
    int          test_errors;

    rv_decode u_rv_decode (.*);

    always #10 clk = ~clk;

    function automatic logic [31:0] fill_word(input int addr);
        return 32'hdead_0000 ^ addr;
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("MISMATCH %s got 0x%08h expected 0x%08h", name, got, exp);
        test_errors++;
    endtask

    task automatic check_ctrl(input logic [11:0] exp);
        if (reg_write !== exp[11]) report_mismatch("reg_write", 32'(reg_write), 32'(exp[11]));
        if (mem_read !== exp[10]) report_mismatch("mem_read", 32'(mem_read), 32'(exp[10]));
        if (mem_write !== exp[9]) report_mismatch("mem_write", 32'(mem_write), 32'(exp[9]));
        if (branch !== exp[8]) report_mismatch("branch", 32'(branch), 32'(exp[8]));
        if (jal !== exp[7]) report_mismatch("jal", 32'(jal), 32'(exp[7]));
        if (jalr !== exp[6]) report_mismatch("jalr", 32'(jalr), 32'(exp[6]));
        if (illegal !== exp[5]) report_mismatch("illegal", 32'(illegal), 32'(exp[5]));
        if (reg_src !== exp[4:3]) report_mismatch("reg_src", 32'(reg_src), 32'(exp[4:3]));
        if (acc_op !== exp[2:0]) report_mismatch("acc_op", 32'(acc_op), 32'(exp[2:0]));
    endtask

    task automatic check_addr(input logic [4:0] e_rs1, input logic [4:0] e_rs2,
                              input logic [4:0] e_rd, input logic [2:0] e_f3);
        if (rs1_addr !== e_rs1) report_mismatch("rs1_addr", 32'(rs1_addr), 32'(e_rs1));
        if (rs2_addr !== e_rs2) report_mismatch("rs2_addr", 32'(rs2_addr), 32'(e_rs2));
        if (rd_addr !== e_rd) report_mismatch("rd_addr", 32'(rd_addr), 32'(e_rd));
        if (funct3 !== e_f3) report_mismatch("funct3", 32'(funct3), 32'(e_f3));
    endtask

    task automatic check_imm(input logic [31:0] exp);
        if (imm !== exp) report_mismatch("imm", imm, exp);
    endtask

    // Register fields come straight from the instruction word
    task automatic check_pattern(input int idx);
        logic [31:0] w;
        w = pat[3 * idx];
        check_ctrl(pat[3 * idx + 1][11:0]);
        check_addr(w[19:15], w[24:20], w[11:7], w[14:12]);
        check_imm(pat[3 * idx + 2]);
    endtask

    task automatic wait_valid(output int cycles, output bit ok);
        cycles = 0;
        ok = 1'b0;
        while (cycles < 20 && !ok) begin
            @(negedge clk);
            if (out_valid === 1'b1) ok = 1'b1;
            else cycles++;
        end
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (test_errors == 0) begin
            $display("test %s ok", name);
        end else begin
            $display("test %s failed with %0d errors", name, test_errors);
            tests_failed++;
        end
        test_errors = 0;
    endtask

    initial begin
        int  cycles;
        bit  ok;
        clk = 1'b0;
        arst_n = 1'b0;
        in_valid = 1'b0;
        instr = 32'd0;
        tests_run = 0;
        tests_failed = 0;
        test_errors = 0;
        n_tests = 0;
        for (int a = 0; a < 384; a++) pat[a] = fill_word(a);
        $readmemh("bench/rv_decode_patterns.hex", pat);
        while (n_tests < 128 && pat[3 * n_tests] !== fill_word(3 * n_tests)) n_tests++;
        if (n_tests == 0) begin
            $display("pattern file holds no tests");
            test_errors++;
            finish_test("load");
        end

        repeat (10) @(posedge clk);
        arst_n <= 1'b1;

        @(negedge clk);
        if (out_valid !== 1'b0) begin
            $display("out_valid is not low after reset");
            test_errors++;
        end
        check_ctrl({7'd0, src_alu, acc_none});
        check_addr(5'd0, 5'd0, 5'd0, 3'd0);
        check_imm(32'd0);
        finish_test("reset");

        for (int i = 0; i < n_tests; i++) begin
            @(posedge clk);
            in_valid <= 1'b1;
            instr <= pat[3 * i];
            @(posedge clk);
            in_valid <= 1'b0;
            wait_valid(cycles, ok);
            if (!ok) begin
                $display("out_valid did not rise within 20 cycles for pattern %0d", i);
                test_errors++;
            end else begin
                check_pattern(i);
            end
            finish_test($sformatf("single %0d", i));
        end

        // Stream every pattern with no gap
        for (int k = 0; k <= n_tests; k++) begin
            @(posedge clk);
            in_valid <= (k < n_tests);
            instr <= (k < n_tests) ? pat[3 * k] : 32'd0;
            if (k > 0) begin
                wait_valid(cycles, ok);
                if (!ok || cycles != 0) begin
                    $display("out_valid late in stream at pattern %0d", k - 1);
                    test_errors++;
                end else begin
                    check_pattern(k - 1);
                end
                finish_test($sformatf("stream %0d", k - 1));
            end
        end
        @(negedge clk);
        if (out_valid !== 1'b0) begin
            $display("out_valid stays high after the stream ends");
            test_errors++;
        end
        finish_test("stream end");

        $display("tests %0d, passed %0d, failed %0d",
                 tests_run, tests_run - tests_failed, tests_failed);
        if (tests_failed == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

/* bench/rv_decode_patterns.hex */
// Columns: instruction, expected control word, expected immediate
// Control word bits: 11 reg_write, 10 mem_read, 9 mem_write, 8 branch, 7 jal, 6 jalr,
// 5 illegal, 4:3 reg_src, 2:0 acc_op
002081b3 800 00000000
407302b3 800 00000000
fff00093 800 ffffffff
7ff58513 800 000007ff
00812203 c08 00000008
ffc40483 c08 fffffffc
00512623 208 0000000c
fe639623 208 ffffffec
00208863 100 00000010
fe419ce3 100 fffffff8
123453b7 800 12345000
fffff417 800 fffff000
001000ef 890 00000800
ffdff06f 090 fffffffc
004280e7 850 00000004
// Accelerator extension
0101810b c09 00000010
0052100b 20a 00000005
0083a30b 003 00000008
0000300b 004 00000000
fff1408b 005 ffffffff
0000d18b 030 00000000
0000f00b 030 00000000
// Unknown opcodes
0000007f 030 00000000
0ff0000f 030 00000000
// Writes to x0
00208033 000 00000000
00000013 000 00000000

/* rv_decode.f */
rtl/rv_decode_pkg.sv
rtl/ctrl_if.sv
rtl/control_decoder.sv
rtl/imm_gen.sv
rtl/decode_merge.sv
rtl/rv_decode.sv
bench/rv_decode_chk.sv
bench/rv_decode_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= rv_decode_tb
FILELIST  ?= rv_decode.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= === PASS ===

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee /dev/stderr | grep -q -F -- '$(PASS_MSG)'

clean:
	rm -rf $(BUILD_DIR)
